/* usb_phy_pkg.sv */
`default_nettype none

package usb_phy_pkg;

	// One byte on the UTMI transmit port
	typedef logic [7:0] byte_t;

	// Transmit controller states
	typedef enum logic [2:0]
	{
		IDLE = 3'd0,
		SOP  = 3'd1,
		DATA = 3'd2,
		EOP1 = 3'd3,
		EOP2 = 3'd4,
		WAIT = 3'd5
	} tx_state_e;

	// DPLL phases, P1 emits the bit enable and is the reset phase
	typedef enum logic [1:0]
	{
		DPLL_P0 = 2'd0,
		DPLL_P1 = 2'd1,
		DPLL_P2 = 2'd2,
		DPLL_P3 = 2'd3
	} dpll_state_e;

	// Bit 1 is D-, bit 0 is D+
	typedef logic [1:0] line_state_t;

	localparam line_state_t LS_SE0 = 2'b00;

	// Sync pattern, sent LSB first as KJKJKJKK
	localparam byte_t SYNC_BYTE = 8'h80;

	// Ones in a row before a stuffed zero
	localparam int unsigned STUFF_LIMIT = 6;

	localparam int unsigned BIT_CNT_W = 3;
	localparam int unsigned RST_CNT_W_DEFAULT = 5;

endpackage

`default_nettype wire

/* usb_tx_bit_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface usb_tx_bit_if;

	logic               tx_ip;
	usb_phy_pkg::byte_t hold_byte;
	logic               ld_eop;
	logic               sft_done;
	logic               eop_done;

	// Controller side of the byte to bit handoff
	modport ctrl_mp
	(
		output tx_ip,
		output hold_byte,
		output ld_eop,
		input  sft_done,
		input  eop_done
	);

	// Serializer side
	modport ser_mp
	(
		input  tx_ip,
		input  hold_byte,
		input  ld_eop,
		output sft_done,
		output eop_done
	);

endinterface

`default_nettype wire

/* usb_line_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_line_sync
(
	input  wire                      usb_rx_phy_clk,
	input  wire                      rxd_i,
	input  wire                      rxdp_i,
	input  wire                      rxdn_i,
	output logic                     rxd_s_o,
	output usb_phy_pkg::line_state_t line_state_o
);

	// Pin order in the sync vectors is {rxdn, rxdp, rxd}
	logic [2:0] pin_s0;
	logic [2:0] pin_s1;
	logic       rxd_flt;

	//////////////////////////////////////////////////////////////////////
	//
	// Input synchronizers
	//

	always_ff @(posedge usb_rx_phy_clk)
	begin
		pin_s0 <= {rxdn_i, rxdp_i, rxd_i};
		pin_s1 <= pin_s0;
	end

	//////////////////////////////////////////////////////////////////////
	//
	// Glitch filter
	//

	// Only move when both stages agree, otherwise hold
	always_ff @(posedge usb_rx_phy_clk)
	begin
		if (pin_s0[0] && pin_s1[0])
			rxd_flt <= 1'b1;
		else if (!pin_s0[0] && !pin_s1[0])
			rxd_flt <= 1'b0;
	end

	assign rxd_s_o = rxd_flt;

	// D- and D+ straight from the second stage
	assign line_state_o = pin_s1[2:1];

endmodule

`default_nettype wire

/* usb_dpll.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_dpll
(
	input  wire  usb_rx_phy_clk,
	input  wire  usb_tx_phy_rst,
	input  wire  rxd_s_i,
	input  wire  lock_en_i,
	output logic fs_ce_o
);

	logic                     lock_en;
	logic                     rxd_r;
	logic                     jump;
	usb_phy_pkg::dpll_state_e state;
	usb_phy_pkg::dpll_state_e next_state;
	logic                     fs_ce_d;
	logic                     fs_ce_r1;
	logic                     fs_ce_r2;

	// Edge detector on the filtered rxd
	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
		begin
			lock_en <= 1'b0;
			rxd_r <= 1'b0;
		end
		else
		begin
			lock_en <= lock_en_i;
			rxd_r <= rxd_s_i;
		end
	end

	// Only track the line while the transmitter is off
	assign jump = lock_en && (rxd_r != rxd_s_i);

	//////////////////////////////////////////////////////////////////////
	//
	// Four phase DPLL
	//

	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
			state <= usb_phy_pkg::DPLL_P1;
		else
			state <= next_state;
	end

	always_comb
	begin
		fs_ce_d = 1'b0;
		next_state = state;
		case (state)
			usb_phy_pkg::DPLL_P0:
				next_state = jump ? usb_phy_pkg::DPLL_P0 : usb_phy_pkg::DPLL_P1;
			usb_phy_pkg::DPLL_P1:
			begin
				fs_ce_d = 1'b1;
				next_state = jump ? usb_phy_pkg::DPLL_P3 : usb_phy_pkg::DPLL_P2;
			end
			usb_phy_pkg::DPLL_P2:
				next_state = jump ? usb_phy_pkg::DPLL_P0 : usb_phy_pkg::DPLL_P3;
			default:
				next_state = usb_phy_pkg::DPLL_P0;
		endcase
	end

	// Three flops make up for the input sync so the enable lands mid bit
	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
		begin
			fs_ce_r1 <= 1'b0;
			fs_ce_r2 <= 1'b0;
			fs_ce_o <= 1'b0;
		end
		else
		begin
			fs_ce_r1 <= fs_ce_d;
			fs_ce_r2 <= fs_ce_r1;
			fs_ce_o <= fs_ce_r2;
		end
	end

endmodule

`default_nettype wire

/* usb_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_tx_ctrl
(
	input  wire                usb_rx_phy_clk,
	input  wire                usb_tx_phy_rst,
	input  wire                fs_ce_i,
	input  wire                tx_valid_i,
	input  usb_phy_pkg::byte_t data_out_i,
	output logic               tx_ready_o,
	usb_tx_bit_if.ctrl_mp      bus
);

	usb_phy_pkg::tx_state_e state;
	usb_phy_pkg::tx_state_e next_state;
	logic                   tx_ready_d;
	logic                   ld_sop_d;
	logic                   ld_data_d;
	logic                   ld_eop_d;
	logic                   ld_data;
	logic                   data_done;
	logic                   tx_ip;
	usb_phy_pkg::byte_t     hold_reg;

	assign bus.tx_ip = tx_ip;
	assign bus.hold_byte = hold_reg;
	assign bus.ld_eop = ld_eop_d;

	//////////////////////////////////////////////////////////////////////
	//
	// Handshake and flags
	//

	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
		begin
			tx_ready_o <= 1'b0;
			ld_data <= 1'b0;
			tx_ip <= 1'b0;
			data_done <= 1'b0;
		end
		else
		begin
			tx_ready_o <= tx_ready_d & tx_valid_i;
			ld_data <= ld_data_d;
			if (ld_sop_d)
				tx_ip <= 1'b1;
			else if (bus.eop_done)
				tx_ip <= 1'b0;
			// Stays up while the host keeps TxValid high
			if (tx_valid_i && !tx_ip)
				data_done <= 1'b1;
			else if (!tx_valid_i)
				data_done <= 1'b0;
		end
	end

	// Hold register, sync first then each accepted byte
	always_ff @(posedge usb_rx_phy_clk)
	begin
		if (ld_sop_d)
			hold_reg <= usb_phy_pkg::SYNC_BYTE;
		else if (ld_data)
			hold_reg <= data_out_i;
	end

	//////////////////////////////////////////////////////////////////////
	//
	// Transmit FSM
	//

	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
			state <= usb_phy_pkg::IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		tx_ready_d = 1'b0;
		ld_sop_d = 1'b0;
		ld_data_d = 1'b0;
		ld_eop_d = 1'b0;
		case (state)
			usb_phy_pkg::IDLE:
				if (tx_valid_i)
				begin
					ld_sop_d = 1'b1;
					next_state = usb_phy_pkg::SOP;
				end
			usb_phy_pkg::SOP:
				if (bus.sft_done)
				begin
					tx_ready_d = 1'b1;
					ld_data_d = 1'b1;
					next_state = usb_phy_pkg::DATA;
				end
			usb_phy_pkg::DATA:
				if (bus.sft_done && data_done)
				begin
					tx_ready_d = 1'b1;
					ld_data_d = 1'b1;
				end
				else if (bus.sft_done)
				begin
					ld_eop_d = 1'b1;
					next_state = usb_phy_pkg::EOP1;
				end
			usb_phy_pkg::EOP1:
				if (bus.eop_done)
					next_state = usb_phy_pkg::EOP2;
			usb_phy_pkg::EOP2:
				if (!bus.eop_done && fs_ce_i)
					next_state = usb_phy_pkg::WAIT;
			usb_phy_pkg::WAIT:
				if (fs_ce_i)
					next_state = usb_phy_pkg::IDLE;
			default:
				next_state = usb_phy_pkg::IDLE;
		endcase
	end

endmodule

`default_nettype wire

/* usb_tx_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_tx_serializer
(
	input  wire          usb_rx_phy_clk,
	input  wire          usb_tx_phy_rst,
	input  wire          fs_ce_i,
	input  wire          phy_mode_i,
	output logic         txdp_o,
	output logic         txdn_o,
	output logic         txoe_o,
	usb_tx_bit_if.ser_mp bus
);

	typedef logic [usb_phy_pkg::BIT_CNT_W-1:0] bit_cnt_t;

	logic               tx_ip_sync;
	usb_phy_pkg::byte_t hold_reg_d;
	bit_cnt_t           bit_cnt;
	logic               sd_raw;
	logic               sft_done;
	logic               sft_done_r;
	logic [2:0]         one_cnt;
	logic               stuff;
	logic               sd_bs;
	logic               sd_nrzi;
	logic               append_eop;
	logic [4:1]         eop_sync;
	logic               txoe_r1;
	logic               txoe_r2;

	assign stuff = (one_cnt == 3'(usb_phy_pkg::STUFF_LIMIT));
	assign bus.sft_done = sft_done & !sft_done_r;
	assign bus.eop_done = eop_sync[3];

	//////////////////////////////////////////////////////////////////////
	//
	// Shifter and bit stuffer
	//

	always_ff @(posedge usb_rx_phy_clk)
	begin
		hold_reg_d <= bus.hold_byte;
		if (!tx_ip_sync)
			sd_raw <= 1'b0;
		else
			sd_raw <= hold_reg_d[bit_cnt];
	end

	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
		begin
			tx_ip_sync <= 1'b0;
			bit_cnt <= '0;
			one_cnt <= '0;
			sd_bs <= 1'b0;
			sft_done <= 1'b0;
			sft_done_r <= 1'b0;
		end
		else
		begin
			sft_done <= !stuff && (bit_cnt == '1);
			sft_done_r <= sft_done;
			if (fs_ce_i)
				tx_ip_sync <= bus.tx_ip;
			if (!tx_ip_sync)
			begin
				bit_cnt <= '0;
				one_cnt <= '0;
			end
			else if (fs_ce_i)
			begin
				// Counter waits while the stuffed zero goes out
				if (!stuff)
					bit_cnt <= bit_cnt + bit_cnt_t'(1);
				one_cnt <= (!sd_raw || stuff) ? 3'd0 : one_cnt + 3'd1;
			end
			if (fs_ce_i)
				sd_bs <= tx_ip_sync && !stuff && sd_raw;
		end
	end

	//////////////////////////////////////////////////////////////////////
	//
	// NRZI encoder and EOP
	//

	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
		begin
			sd_nrzi <= 1'b1;
			append_eop <= 1'b0;
			eop_sync <= '0;
		end
		else
		begin
			// Idle level is J, a zero toggles the line
			if (!tx_ip_sync || !txoe_r1)
				sd_nrzi <= 1'b1;
			else if (fs_ce_i && !sd_bs)
				sd_nrzi <= !sd_nrzi;
			if (bus.ld_eop)
				append_eop <= 1'b1;
			else if (eop_sync[2])
				append_eop <= 1'b0;
			if (fs_ce_i)
			begin
				eop_sync[1] <= append_eop;
				eop_sync[2] <= eop_sync[1];
				// Stretch so SE0 is always two bits
				eop_sync[3] <= eop_sync[2] | (eop_sync[3] & !eop_sync[4]);
				eop_sync[4] <= eop_sync[3];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	//
	// Output enable and pin registers
	//

	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
		begin
			txoe_r1 <= 1'b0;
			txoe_r2 <= 1'b0;
			txoe_o <= 1'b1;
			txdp_o <= 1'b1;
			txdn_o <= 1'b0;
		end
		else if (fs_ce_i)
		begin
			txoe_r1 <= tx_ip_sync;
			txoe_r2 <= txoe_r1;
			txoe_o <= !(txoe_r1 | txoe_r2);
			if (phy_mode_i)
			begin
				// Differential J/K, both low for SE0
				txdp_o <= !eop_sync[3] & sd_nrzi;
				txdn_o <= !eop_sync[3] & !sd_nrzi;
			end
			else
			begin
				txdp_o <= sd_nrzi;
				txdn_o <= eop_sync[3];
			end
		end
	end

endmodule

`default_nettype wire

/* usb_bus_reset_det.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_bus_reset_det
#(
	parameter int RST_CNT_W = usb_phy_pkg::RST_CNT_W_DEFAULT
)
(
	input  wire                      usb_rx_phy_clk,
	input  wire                      usb_tx_phy_rst,
	input  wire                      fs_ce_i,
	input  usb_phy_pkg::line_state_t line_state_i,
	output logic                     usb_rst_o
);

	logic [RST_CNT_W-1:0] rst_cnt;

	// Count bit times of SE0, freeze once reset is flagged
	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
		begin
			rst_cnt <= '0;
			usb_rst_o <= 1'b0;
		end
		else
		begin
			if (line_state_i != usb_phy_pkg::LS_SE0)
				rst_cnt <= '0;
			else if (!usb_rst_o && fs_ce_i)
				rst_cnt <= rst_cnt + RST_CNT_W'(1);
			usb_rst_o <= &rst_cnt;
		end
	end

endmodule

`default_nettype wire

/* usb_phy_top.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_phy_top
#(
	parameter int RST_CNT_W = usb_phy_pkg::RST_CNT_W_DEFAULT
)
(
	input  wire         usb_rx_phy_clk,
	input  wire         usb_tx_phy_rst,
	input  wire         phy_tx_mode_i,
	input  wire         rxd_i,
	input  wire         rxdp_i,
	input  wire         rxdn_i,
	input  wire  [7:0]  data_out_i,
	input  wire         tx_valid_i,
	output logic        tx_ready_o,
	output logic        txdp_o,
	output logic        txdn_o,
	output logic        txoe_o,
	output logic [1:0]  line_state_o,
	output logic        usb_rst_o
);

	logic fs_ce;
	logic rxd_s;

	usb_tx_bit_if u_tx_bit ();

	//////////////////////////////////////////////////////////////////////
	//
	// Line side and bit clock
	//

	usb_line_sync u_line_sync (
		.usb_rx_phy_clk (usb_rx_phy_clk),
		.rxd_i          (rxd_i),
		.rxdp_i         (rxdp_i),
		.rxdn_i         (rxdn_i),
		.rxd_s_o        (rxd_s),
		.line_state_o   (line_state_o)
	);

	// Locks only while txoe is high
	usb_dpll u_dpll (
		.usb_rx_phy_clk (usb_rx_phy_clk),
		.usb_tx_phy_rst (usb_tx_phy_rst),
		.rxd_s_i        (rxd_s),
		.lock_en_i      (txoe_o),
		.fs_ce_o        (fs_ce)
	);

	//////////////////////////////////////////////////////////////////////
	//
	// Transmit path
	//

	usb_tx_ctrl u_tx_ctrl (
		.usb_rx_phy_clk (usb_rx_phy_clk),
		.usb_tx_phy_rst (usb_tx_phy_rst),
		.fs_ce_i        (fs_ce),
		.tx_valid_i     (tx_valid_i),
		.data_out_i     (data_out_i),
		.tx_ready_o     (tx_ready_o),
		.bus            (u_tx_bit.ctrl_mp)
	);

	usb_tx_serializer u_tx_serializer (
		.usb_rx_phy_clk (usb_rx_phy_clk),
		.usb_tx_phy_rst (usb_tx_phy_rst),
		.fs_ce_i        (fs_ce),
		.phy_mode_i     (phy_tx_mode_i),
		.txdp_o         (txdp_o),
		.txdn_o         (txdn_o),
		.txoe_o         (txoe_o),
		.bus            (u_tx_bit.ser_mp)
	);

	usb_bus_reset_det #(
		.RST_CNT_W (RST_CNT_W)
	) u_bus_reset_det (
		.usb_rx_phy_clk (usb_rx_phy_clk),
		.usb_tx_phy_rst (usb_tx_phy_rst),
		.fs_ce_i        (fs_ce),
		.line_state_i   (line_state_o),
		.usb_rst_o      (usb_rst_o)
	);

endmodule

`default_nettype wire

/* usb_phy_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_phy_assert
(
	input wire usb_rx_phy_clk,
	input wire usb_tx_phy_rst,
	input wire phy_tx_mode_i,
	input wire tx_valid_i,
	input wire tx_ready_i,
	input wire tx_ip_i,
	input wire txdp_i,
	input wire txdn_i,
	input wire txoe_i
);

	// Clocks since transmit in progress went low, saturating
	logic [4:0] idle_cnt;

	always_ff @(posedge usb_rx_phy_clk or negedge usb_tx_phy_rst)
	begin
		if (!usb_tx_phy_rst)
			idle_cnt <= '0;
		else if (tx_ip_i)
			idle_cnt <= '0;
		else if (idle_cnt != 5'd24)
			idle_cnt <= idle_cnt + 5'd1;
	end

	// TxReady only answers a TxValid seen the cycle before
	ready_after_valid: assert property (@(posedge usb_rx_phy_clk) disable iff (!usb_tx_phy_rst)
		tx_ready_i |-> $past(tx_valid_i))
		else $error("TxReady without TxValid");

	// Differential pins never both high
	no_se1: assert property (@(posedge usb_rx_phy_clk) disable iff (!usb_tx_phy_rst)
		phy_tx_mode_i |-> !(txdp_i && txdn_i))
		else $error("txdp and txdn both high");

	// Long after the packet the driver is off
	oe_idle: assert property (@(posedge usb_rx_phy_clk) disable iff (!usb_tx_phy_rst)
		(idle_cnt == 5'd24) |-> txoe_i)
		else $error("txoe low outside transmission");

endmodule

bind usb_phy_top usb_phy_assert u_phy_assert (
	.usb_rx_phy_clk (usb_rx_phy_clk),
	.usb_tx_phy_rst (usb_tx_phy_rst),
	.phy_tx_mode_i  (phy_tx_mode_i),
	.tx_valid_i     (tx_valid_i),
	.tx_ready_i     (tx_ready_o),
	.tx_ip_i        (u_tx_bit.tx_ip),
	.txdp_i         (txdp_o),
	.txdn_i         (txdn_o),
	.txoe_i         (txoe_o)
);

`default_nettype wire

/* tb_usb_phy.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_usb_phy;

	typedef usb_phy_pkg::line_state_t sym_q_t[$];
	typedef usb_phy_pkg::byte_t byte_q_t[$];

	// Bits of all three packets with worst case stuffing
	localparam int PKT_BITS = 28 + 84 + 84;
	// Reset and line tests, then margin
	localparam int TIMEOUT_CLKS = PKT_BITS * 4 + 400 + 1000;
	// Reset counter must fill to all ones, one bit time per count
	localparam int RST_MIN_CLKS = ((1 << usb_phy_pkg::RST_CNT_W_DEFAULT) - 1) * 4;

	logic        usb_rx_phy_clk;
	logic        usb_tx_phy_rst;
	logic        phy_tx_mode;
	logic        rxd;
	logic        rxdp;
	logic        rxdn;
	logic [7:0]  data_out;
	logic        tx_valid;
	logic        tx_ready;
	logic        txdp;
	logic        txdn;
	logic        txoe;
	logic [1:0]  line_state;
	logic        usb_rst;
	int          ready_cnt;
	int unsigned lcg_state;
	byte_q_t     pkt;

	usb_phy_top u_usb_phy_top (
		.usb_rx_phy_clk (usb_rx_phy_clk),
		.usb_tx_phy_rst (usb_tx_phy_rst),
		.phy_tx_mode_i  (phy_tx_mode),
		.rxd_i          (rxd),
		.rxdp_i         (rxdp),
		.rxdn_i         (rxdn),
		.data_out_i     (data_out),
		.tx_valid_i     (tx_valid),
		.tx_ready_o     (tx_ready),
		.txdp_o         (txdp),
		.txdn_o         (txdn),
		.txoe_o         (txoe),
		.line_state_o   (line_state),
		.usb_rst_o      (usb_rst)
	);

	always #20 usb_rx_phy_clk = !usb_rx_phy_clk;

	always @(negedge usb_rx_phy_clk)
	begin
		if (tx_ready)
			ready_cnt <= ready_cnt + 1;
	end

	initial
	begin
		#(TIMEOUT_CLKS * 40);
		$display("Watchdog expired, the DUT stopped responding");
		$display("TESTBENCH FAILED");
		$fatal(1, "timeout");
	end

	//////////////////////////////////////////////////////////////////////
	//
	// Reference model and compare tasks
	//

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Pin symbols as {txdn, txdp}, the same bit order as line_state_t
	function automatic sym_q_t expected_symbols(input logic mode, input byte_q_t bytes);
		sym_q_t     syms;
		logic       bits[$];
		byte_q_t    all;
		int         ones;
		logic       lvl;
		all = bytes;
		all.push_front(usb_phy_pkg::SYNC_BYTE);
		ones = 0;
		foreach (all[i])
			for (int b = 0; b < 8; b++)
			begin
				bits.push_back(all[i][b]);
				ones = all[i][b] ? ones + 1 : 0;
				if (ones == usb_phy_pkg::STUFF_LIMIT)
				begin
					bits.push_back(1'b0);
					ones = 0;
				end
			end
		lvl = 1'b1;
		// Idle level before the sync pattern
		syms.push_back(mode ? {!lvl, lvl} : {1'b0, lvl});
		foreach (bits[i])
		begin
			if (!bits[i])
				lvl = !lvl;
			syms.push_back(mode ? {!lvl, lvl} : {1'b0, lvl});
		end
		syms.push_back(mode ? 2'b00 : 2'b10);
		syms.push_back(mode ? 2'b00 : 2'b10);
		// J after the EOP looks the same in both encodings
		syms.push_back(2'b01);
		return syms;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s at %0t", msg, $time);
		$display("TESTBENCH FAILED");
		$fatal(1, "check failed");
	endtask

	// In mode 0 the D+ pin carries no meaning during SE0
	task automatic check_pin(input logic mode, input usb_phy_pkg::line_state_t got,
		input usb_phy_pkg::line_state_t exp);
		if ((!mode && exp[1]) ? (got[1] !== 1'b1) : (got !== exp))
		begin
			$display("** Error at %0t: {txdn_o,txdp_o} got %b expected %b", $time, got, exp);
			fail_now("Pin symbol mismatch");
		end
	endtask

	task automatic check_line(input usb_phy_pkg::line_state_t got,
		input usb_phy_pkg::line_state_t exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: line_state_o got %b expected %b", $time, got, exp);
			fail_now("Line state mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
			fail_now("Flag mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	//
	// Packet driver and pin checker
	//

	task automatic drive_bytes(input byte_q_t bytes);
		int   idx;
		logic pend;
		idx = 0;
		pend = 1'b0;
		@(negedge usb_rx_phy_clk);
		data_out = bytes[0];
		tx_valid = 1'b1;
		while (tx_valid)
		begin
			@(negedge usb_rx_phy_clk);
			// Byte was taken on the edge after the TxReady pulse
			if (pend)
			begin
				pend = 1'b0;
				idx++;
				if (idx < bytes.size())
					data_out = bytes[idx];
				else
					tx_valid = 1'b0;
			end
			if (tx_ready)
				pend = 1'b1;
		end
	endtask

	task automatic check_packet(input logic mode, input byte_q_t bytes);
		sym_q_t exp;
		exp = expected_symbols(mode, bytes);
		@(negedge txoe);
		repeat (2) @(negedge usb_rx_phy_clk);
		foreach (exp[i])
		begin
			check_flag("txoe_o", txoe, 1'b0);
			check_pin(mode, {txdn, txdp}, exp[i]);
			repeat (4) @(negedge usb_rx_phy_clk);
		end
		check_flag("txoe_o", txoe, 1'b1);
	endtask

	task automatic run_packet(input logic mode, input byte_q_t bytes);
		phy_tx_mode = mode;
		ready_cnt = 0;
		fork
			drive_bytes(bytes);
			check_packet(mode, bytes);
		join
		repeat (40) @(negedge usb_rx_phy_clk);
		if (ready_cnt != bytes.size())
			fail_now("TxReady pulse count does not match the byte count");
	endtask

	initial
	begin
		usb_rx_phy_clk = 1'b0;
		usb_tx_phy_rst = 1'b0;
		phy_tx_mode = 1'b1;
		rxd = 1'b1;
		rxdp = 1'b1;
		rxdn = 1'b0;
		data_out = 8'h00;
		tx_valid = 1'b0;
		ready_cnt = 0;
		lcg_state = 32'd32;
		repeat (4) @(negedge usb_rx_phy_clk);
		usb_tx_phy_rst = 1'b1;
		@(negedge usb_rx_phy_clk);
		check_flag("txoe_o", txoe, 1'b1);
		check_flag("txdp_o", txdp, 1'b1);
		check_flag("txdn_o", txdn, 1'b0);
		check_flag("tx_ready_o", tx_ready, 1'b0);
		check_flag("usb_rst_o", usb_rst, 1'b0);
		repeat (10) @(negedge usb_rx_phy_clk);

		pkt = '{8'h2D};
		run_packet(1'b1, pkt);

		// Random bytes, then a long run of ones to force stuffing
		pkt = {};
		for (int i = 0; i < 5; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			pkt.push_back(lcg_state[23:16]);
		end
		pkt.push_back(8'hFF);
		pkt.push_back(8'h3F);
		run_packet(1'b1, pkt);
		run_packet(1'b0, pkt);

		for (int v = 0; v < 4; v++)
		begin
			@(negedge usb_rx_phy_clk);
			{rxdn, rxdp} = 2'(v);
			repeat (3) @(negedge usb_rx_phy_clk);
			check_line(line_state, 2'(v));
		end

		//////////////////////////////////////////////////////////////////////
		//
		// Bus reset detection
		//
		@(negedge usb_rx_phy_clk);
		{rxdn, rxdp} = 2'b00;
		for (int c = 1; c <= 200; c++)
		begin
			@(negedge usb_rx_phy_clk);
			if (usb_rst && c < RST_MIN_CLKS)
				fail_now("USB reset flagged too early");
		end
		check_flag("usb_rst_o", usb_rst, 1'b1);
		{rxdn, rxdp} = 2'b01;
		repeat (5) @(negedge usb_rx_phy_clk);
		check_flag("usb_rst_o", usb_rst, 1'b0);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
usb_phy_pkg.sv
usb_tx_bit_if.sv
usb_line_sync.sv
usb_dpll.sv
usb_tx_ctrl.sv
usb_tx_serializer.sv
usb_bus_reset_det.sv
usb_phy_top.sv
usb_phy_assert.sv
tb_usb_phy.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wall -Wno-fatal -f list.f --top-module tb_usb_phy -o sim \
	&& ./obj_dir/sim \
	|| exit 1
